/* include/uart_hub_defines.svh */
/*
 * uart string hub build constants
 * channel count, bit timing, payload limit and frame delimiter
 */
`ifndef UART_HUB_DEFINES_SVH
`define UART_HUB_DEFINES_SVH

// number of independent serial channels
`define UART_NUM_CH 4

// system clocks per serial bit
`define UART_CLKS_PER_BIT 16

// payload bytes per string
`define UART_MAX_LEN 16

// frame delimiter, ASCII '&'
`define UART_DELIM 8'h26

`endif

/* source/uart_data_pkg.sv */
/*
 * uart string hub data types
 * payload vectors and the structs passed between blocks
 */
`include "uart_hub_defines.svh"

package uart_data_pkg;

	typedef logic [7:0]                   uart_byte_t;
	typedef logic [4:0]                   str_len_t;
	typedef logic [`UART_MAX_LEN*8-1:0]   str_data_t;
	typedef logic [1:0]                   chan_id_t;

	// byte 0 sits in data[7:0]
	typedef struct packed {
		str_data_t data;
		str_len_t  length;
	} tx_string_s;

	typedef struct packed {
		chan_id_t  chan;
		str_data_t data;
		str_len_t  length;
	} rx_frame_s;

endpackage

/* source/uart_ctrl_pkg.sv */
/*
 * uart string hub control types
 * state encodings of the byte engines and the frame framers
 */
package uart_ctrl_pkg;

	// one serial byte: start bit, eight data bits, stop bits
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} byte_state_e;

	// each state names the byte currently on the line
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SIGN1,
		TX_SIGN2,
		TX_CONTENT,
		TX_SIGN3,
		TX_SIGN4,
		TX_FINISH
	} frame_tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_SIGN1,
		RX_CONTENT,
		RX_SIGN3,
		RX_FINISH
	} frame_rx_state_e;

endpackage

/* source/uart_tx_dispatch.sv */
/*
 * tx dispatcher
 * holds one host string and starts the target channel once it is idle
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_tx_dispatch
	import uart_data_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    req,
	input  chan_id_t                chan,
	input  tx_string_s              str,
	input  logic [`UART_NUM_CH-1:0] chan_active,
	output logic                    busy,
	output logic [`UART_NUM_CH-1:0] start,
	output tx_string_s              held_str
);

	logic     held_valid;
	chan_id_t held_chan;

	assign busy = held_valid;

	// request is dropped while an entry is already held
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			held_valid <= 1'b0;
		end else if (req && !held_valid) begin
			held_valid <= 1'b1;
		end else if (|start) begin
			held_valid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (req && !held_valid) begin
			held_chan <= chan;
			held_str  <= str;
		end
	end

	// fire as soon as the chosen channel has finished its last frame
	always_comb begin
		for (int i = 0; i < `UART_NUM_CH; i++) begin
			start[i] = held_valid && (held_chan == chan_id_t'(i)) && !chan_active[i];
		end
	end

	// a started channel reports itself active on the next cycle
	a_start_taken: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		|start |=> (chan_active & $past(start)) == $past(start));

endmodule

/* source/uart_byte_tx.sv */
/*
 * uart byte transmitter
 * 8N2 serializer, LSB first, one bit every CLKS_PER_BIT clocks
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_byte_tx
	import uart_data_pkg::*;
	import uart_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       start,
	input  uart_byte_t data,
	output logic       txd,
	output logic       done
);

	localparam int CNT_W = $clog2(2 * `UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] STOP_LAST = CNT_W'(2 * `UART_CLKS_PER_BIT - 1);

	byte_state_e      state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= IDLE;
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (start) begin
						state <= START;
					end
				end
				START: begin
					cnt <= (cnt == BIT_LAST) ? '0 : cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						state <= DATA;
					end
				end
				DATA: begin
					cnt <= (cnt == BIT_LAST) ? '0 : cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= STOP;
						end
					end
				end
				// both stop bits in one stretch
				STOP: begin
					cnt <= (cnt == STOP_LAST) ? '0 : cnt + 1'b1;
					if (cnt == STOP_LAST) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == IDLE && start) begin
			shreg <= data;
		end else if (state == DATA && cnt == BIT_LAST) begin
			shreg <= shreg >> 1;
		end
	end

	assign txd  = (state == START) ? 1'b0 : (state == DATA) ? shreg[0] : 1'b1;
	assign done = (state == STOP) && (cnt == STOP_LAST);

	a_start_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		start |-> state == IDLE);

endmodule

/* source/uart_byte_rx.sv */
/*
 * uart byte receiver
 * synchronizes rxd, finds the start edge and samples every bit at mid-bit
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_byte_rx
	import uart_data_pkg::*;
	import uart_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output uart_byte_t data,
	output logic       vld
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

	byte_state_e      state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [1:0]       rx_sync;
	logic             rx_prev;
	logic             rx_s;

	assign rx_s = rx_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			state   <= IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			vld     <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rxd};
			rx_prev <= rx_s;
			vld     <= 1'b0;
			case (state)
				IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_s) begin
						state <= START;
					end
				end
				// a start bit that is high again at its middle was a glitch
				START: begin
					cnt <= (cnt == HALF_LAST) ? '0 : cnt + 1'b1;
					if (cnt == HALF_LAST) begin
						state <= rx_s ? IDLE : DATA;
					end
				end
				DATA: begin
					cnt <= (cnt == BIT_LAST) ? '0 : cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= STOP;
						end
					end
				end
				STOP: begin
					cnt <= (cnt == BIT_LAST) ? '0 : cnt + 1'b1;
					if (cnt == BIT_LAST) begin
						state <= IDLE;
						vld   <= rx_s;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == DATA && cnt == BIT_LAST) begin
			data <= {rx_s, data[7:1]};
		end
	end

endmodule

/* source/uart_frame_channel.sv */
/*
 * uart frame channel
 * wraps strings as &&payload&& on tx and unwraps them on rx
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_frame_channel
	import uart_data_pkg::*;
	import uart_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       start,
	input  tx_string_s str,
	input  logic       rxd,
	output logic       txd,
	output logic       tx_active,
	output logic       tx_done,
	output str_data_t  rx_data,
	output str_len_t   rx_len,
	output logic       rx_done
);

	localparam str_len_t MAX_LEN = str_len_t'(`UART_MAX_LEN);

	frame_tx_state_e tx_state;
	tx_string_s      tx_buf;
	str_len_t        tx_idx;
	logic            byte_start;
	uart_byte_t      byte_data;
	logic            byte_done;

	frame_rx_state_e rx_state;
	uart_byte_t      rx_byte;
	logic            rx_vld;
	logic            is_delim;
	logic            is_other;
	logic            open_ok;
	logic            store_one;
	logic            store_two;
	str_len_t        pos_next;

	always_ff @(posedge sys_clk) begin
		if (tx_state == TX_IDLE && start) begin
			tx_buf.data   <= str.data;
			tx_buf.length <= (str.length > MAX_LEN) ? MAX_LEN : str.length;
		end
	end

	// byte_start is the reload pulse, one idle cycle after each byte's done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state   <= TX_IDLE;
			tx_idx     <= '0;
			byte_start <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			case (tx_state)
				TX_IDLE: begin
					if (start) begin
						tx_state   <= TX_SIGN1;
						byte_start <= 1'b1;
					end
				end
				TX_SIGN1: begin
					if (byte_done) begin
						tx_state   <= TX_SIGN2;
						byte_start <= 1'b1;
					end
				end
				TX_SIGN2: begin
					if (byte_done) begin
						tx_state   <= (tx_buf.length == '0) ? TX_SIGN3 : TX_CONTENT;
						tx_idx     <= '0;
						byte_start <= 1'b1;
					end
				end
				TX_CONTENT: begin
					if (byte_done) begin
						byte_start <= 1'b1;
						if (str_len_t'(tx_idx + 1'b1) == tx_buf.length) begin
							tx_state <= TX_SIGN3;
						end else begin
							tx_idx <= tx_idx + 1'b1;
						end
					end
				end
				TX_SIGN3: begin
					if (byte_done) begin
						tx_state   <= TX_SIGN4;
						byte_start <= 1'b1;
					end
				end
				TX_SIGN4: begin
					if (byte_done) begin
						tx_state <= TX_FINISH;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign byte_data = (tx_state == TX_CONTENT) ? tx_buf.data[8*tx_idx +: 8] : `UART_DELIM;
	assign tx_active = (tx_state != TX_IDLE);
	assign tx_done   = (tx_state == TX_FINISH);

	uart_byte_tx uart_byte_tx_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.start     (byte_start),
		.data      (byte_data),
		.txd       (txd),
		.done      (byte_done)
	);

	uart_byte_rx uart_byte_rx_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (rxd),
		.data      (rx_byte),
		.vld       (rx_vld)
	);

	assign is_delim  = rx_vld && (rx_byte == `UART_DELIM);
	assign is_other  = rx_vld && (rx_byte != `UART_DELIM);
	assign open_ok   = (rx_state == RX_SIGN1) && is_delim;
	assign store_one = (rx_state == RX_CONTENT) && is_other;
	// a lone & followed by data is kept together with that byte
	assign store_two = (rx_state == RX_SIGN3) && is_other;
	assign pos_next  = rx_len + 1'b1;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= RX_IDLE;
			rx_len   <= '0;
		end else begin
			case (rx_state)
				RX_IDLE:    rx_state <= is_delim ? RX_SIGN1 : RX_IDLE;
				RX_SIGN1:   rx_state <= is_delim ? RX_CONTENT : (rx_vld ? RX_IDLE : RX_SIGN1);
				RX_CONTENT: rx_state <= is_delim ? RX_SIGN3 : RX_CONTENT;
				RX_SIGN3:   rx_state <= is_delim ? RX_FINISH : (rx_vld ? RX_CONTENT : RX_SIGN3);
				default:    rx_state <= RX_IDLE;
			endcase
			if (open_ok) begin
				rx_len <= '0;
			end else if (store_one && rx_len < MAX_LEN) begin
				rx_len <= pos_next;
			end else if (store_two) begin
				rx_len <= (pos_next >= MAX_LEN) ? MAX_LEN : str_len_t'(rx_len + 2'd2);
			end
		end
	end

	// bytes past MAX_LEN fall on the floor
	always_ff @(posedge sys_clk) begin
		if (open_ok) begin
			rx_data <= '0;
		end else if (store_one && rx_len < MAX_LEN) begin
			rx_data[8*rx_len +: 8] <= rx_byte;
		end else if (store_two) begin
			if (rx_len < MAX_LEN) begin
				rx_data[8*rx_len +: 8] <= `UART_DELIM;
			end
			if (pos_next < MAX_LEN) begin
				rx_data[8*pos_next +: 8] <= rx_byte;
			end
		end
	end

	assign rx_done = (rx_state == RX_FINISH);

	a_rx_len_max: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_vld |=> rx_len <= MAX_LEN);

endmodule

/* source/uart_frame_collector.sv */
/*
 * uart frame collector
 * queues finished rx frames per channel and emits them lowest channel first
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_frame_collector
	import uart_data_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic [`UART_NUM_CH-1:0] done,
	input  str_data_t               data [`UART_NUM_CH],
	input  str_len_t                len [`UART_NUM_CH],
	output rx_frame_s               frame,
	output logic                    valid
);

	logic [`UART_NUM_CH-1:0] pending;
	logic [`UART_NUM_CH-1:0] grant;
	chan_id_t                sel;

	// scan downwards so the lowest pending channel wins
	always_comb begin
		grant = '0;
		sel   = '0;
		for (int i = `UART_NUM_CH - 1; i >= 0; i--) begin
			if (pending[i]) begin
				grant = `UART_NUM_CH'(1) << i;
				sel   = chan_id_t'(i);
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pending <= '0;
			valid   <= 1'b0;
		end else begin
			pending <= (pending & ~grant) | done;
			valid   <= |pending;
		end
	end

	// channel data stays put until its next frame opens
	always_ff @(posedge sys_clk) begin
		if (|pending) begin
			frame.chan   <= sel;
			frame.data   <= data[sel];
			frame.length <= len[sel];
		end
	end

endmodule

/* source/uart_string_hub.sv */
/*
 * uart string hub top level
 * one tx dispatcher, NUM_CH frame channels and one rx frame collector
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_string_hub
	import uart_data_pkg::*;
(
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    tx_req,
	input  chan_id_t                tx_chan,
	input  tx_string_s              tx_str,
	input  logic [`UART_NUM_CH-1:0] uart_rx,
	output logic                    tx_busy,
	output logic [`UART_NUM_CH-1:0] tx_done,
	output logic [`UART_NUM_CH-1:0] uart_tx,
	output rx_frame_s               rx_frame,
	output logic                    rx_valid
);

	logic [`UART_NUM_CH-1:0] ch_start;
	logic [`UART_NUM_CH-1:0] ch_active;
	logic [`UART_NUM_CH-1:0] ch_rx_done;
	tx_string_s              held_str;
	str_data_t               ch_rx_data [`UART_NUM_CH];
	str_len_t                ch_rx_len [`UART_NUM_CH];

	uart_tx_dispatch uart_tx_dispatch_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.req         (tx_req),
		.chan        (tx_chan),
		.str         (tx_str),
		.chan_active (ch_active),
		.busy        (tx_busy),
		.start       (ch_start),
		.held_str    (held_str)
	);

	for (genvar i = 0; i < `UART_NUM_CH; i++) begin : g_chan
		uart_frame_channel uart_frame_channel_inst (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.start     (ch_start[i]),
			.str       (held_str),
			.rxd       (uart_rx[i]),
			.txd       (uart_tx[i]),
			.tx_active (ch_active[i]),
			.tx_done   (tx_done[i]),
			.rx_data   (ch_rx_data[i]),
			.rx_len    (ch_rx_len[i]),
			.rx_done   (ch_rx_done[i])
		);
	end

	uart_frame_collector uart_frame_collector_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.done      (ch_rx_done),
		.data      (ch_rx_data),
		.len       (ch_rx_len),
		.frame     (rx_frame),
		.valid     (rx_valid)
	);

endmodule

/* verification/uart_string_hub_tb.sv */
/*
 * uart string hub testbench
 * runs loopback and raw serial vectors from a stimulus file
 * and checks every collected rx frame and tx_done pulse
 */
`timescale 1ns/1ps
`include "uart_hub_defines.svh"

module uart_string_hub_tb
	import uart_data_pkg::*;
();

	localparam int    NUM_CH    = `UART_NUM_CH;
	localparam int    CLKS      = `UART_CLKS_PER_BIT;
	localparam int    MAX_VEC   = 32;
	localparam int    MAX_BYTES = 32;
	localparam string STIM_FILE = "verification/uart_hub_stimulus.txt";

	logic              sys_clk;
	logic              sys_rst_n;
	logic              tx_req;
	chan_id_t          tx_chan;
	tx_string_s        tx_str;
	logic [NUM_CH-1:0] uart_rx;
	logic              tx_busy;
	logic [NUM_CH-1:0] tx_done;
	logic [NUM_CH-1:0] uart_tx;
	rx_frame_s         rx_frame;
	logic              rx_valid;

	// each rx line follows its own tx line or the raw serial driver
	logic [NUM_CH-1:0] loop_sel;
	logic [NUM_CH-1:0] raw_rx;

	rx_frame_s   rx_q[$];
	logic        busy_at_done[$];
	int          done_cnt [NUM_CH];
	int          rx_rd;
	logic [31:0] lfsr_state;
	longint      limit_ns;

	logic [7:0] vec_mode [MAX_VEC];
	chan_id_t   vec_chan [MAX_VEC];
	int         vec_cnt [MAX_VEC];
	int         vec_exp_cnt [MAX_VEC];
	uart_byte_t vec_bytes [MAX_VEC][MAX_BYTES];
	uart_byte_t vec_exp [MAX_VEC][MAX_BYTES];
	int         num_vec;

	assign uart_rx = (uart_tx & loop_sel) | (raw_rx & ~loop_sel);

	uart_string_hub uart_string_hub_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_chan   (tx_chan),
		.tx_str    (tx_str),
		.uart_rx   (uart_rx),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.uart_tx   (uart_tx),
		.rx_frame  (rx_frame),
		.rx_valid  (rx_valid)
	);

	always #50 sys_clk = ~sys_clk;

	// outputs are taken at the falling edge, half a period after they change
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (rx_valid) begin
				rx_q.push_back(rx_frame);
			end
			for (int i = 0; i < NUM_CH; i++) begin
				if (tx_done[i]) begin
					done_cnt[i]++;
					busy_at_done.push_back(tx_busy);
				end
			end
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_len(input str_len_t got, input str_len_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %0d ns: rx length %0d, expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic check_frame(input rx_frame_s got, input rx_frame_s exp);
		if (got.chan !== exp.chan) begin
			stop_on_error($sformatf("[FAIL] %0d ns: rx frame from channel %0d, expected %0d",
				$time, got.chan, exp.chan));
		end
		check_len(got.length, exp.length);
		for (int k = 0; k < int'(exp.length); k++) begin
			if (got.data[8*k +: 8] !== exp.data[8*k +: 8]) begin
				stop_on_error($sformatf("[FAIL] %0d ns: rx byte %0d is %h, expected %h",
					$time, k, got.data[8*k +: 8], exp.data[8*k +: 8]));
			end
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_on_error($sformatf("[FAIL] %0d ns: %s %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	task automatic load_vectors();
		int    fd;
		int    rc;
		int    value;
		int    cnt;
		string tok;
		string rest;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stop_on_error("could not open the stimulus file");
		end
		num_vec = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok[0] == "#") begin
				rc = $fgets(rest, fd);
			end else begin
				if (num_vec == MAX_VEC) begin
					stop_on_error("the stimulus file holds too many vectors");
				end
				vec_mode[num_vec] = tok[0];
				rc = $fscanf(fd, "%d %d", value, cnt);
				if (rc != 2 || cnt > MAX_BYTES) begin
					stop_on_error("the stimulus file holds a malformed vector line");
				end
				vec_chan[num_vec] = chan_id_t'(value);
				vec_cnt[num_vec]  = cnt;
				for (int k = 0; k < cnt; k++) begin
					rc = $fscanf(fd, "%h", value);
					if (rc != 1) begin
						stop_on_error("the stimulus file ends inside a byte list");
					end
					vec_bytes[num_vec][k] = uart_byte_t'(value);
				end
				rc = $fscanf(fd, "%d", cnt);
				if (rc != 1 || cnt > MAX_BYTES) begin
					stop_on_error("the stimulus file holds a malformed expected length");
				end
				vec_exp_cnt[num_vec] = cnt;
				for (int k = 0; k < cnt; k++) begin
					rc = $fscanf(fd, "%h", value);
					if (rc != 1) begin
						stop_on_error("the stimulus file ends inside an expected byte list");
					end
					vec_exp[num_vec][k] = uart_byte_t'(value);
				end
				num_vec++;
			end
		end
		$fclose(fd);
	endtask

	// serial bytes of all vectors, framing delimiters included
	function automatic int vector_bytes();
		int total;
		total = 0;
		for (int n = 0; n < num_vec; n++) begin
			case (vec_mode[n])
				"L":     total += vec_cnt[n] + 4;
				"P":     total += vec_cnt[n] + vec_exp_cnt[n] + 8;
				default: total += vec_cnt[n];
			endcase
		end
		return total;
	endfunction

	function automatic rx_frame_s make_frame(input chan_id_t ch, input int n, input logic exp);
		rx_frame_s f;
		int        cnt;
		f      = '0;
		f.chan = ch;
		cnt    = exp ? vec_exp_cnt[n] : vec_cnt[n];
		f.length = str_len_t'(cnt);
		for (int k = 0; k < cnt && k < `UART_MAX_LEN; k++) begin
			f.data[8*k +: 8] = exp ? vec_exp[n][k] : vec_bytes[n][k];
		end
		return f;
	endfunction

	function automatic tx_string_s payload_of(input rx_frame_s f);
		tx_string_s s;
		s.data   = f.data;
		s.length = f.length;
		return s;
	endfunction

	task automatic host_pulse(input chan_id_t ch, input tx_string_s s);
		@(posedge sys_clk);
		#1;
		tx_req  = 1'b1;
		tx_chan = ch;
		tx_str  = s;
		@(posedge sys_clk);
		#1;
		tx_req  = 1'b0;
	endtask

	task automatic send_when_free(input chan_id_t ch, input tx_string_s s);
		@(negedge sys_clk);
		while (tx_busy) begin
			@(negedge sys_clk);
		end
		host_pulse(ch, s);
	endtask

	// start bit, eight data bits lsb first, two stop bits, then a random idle gap
	task automatic send_raw_byte(input logic [NUM_CH-1:0] mask, input uart_byte_t b);
		logic [10:0] bits;
		int          gap;
		bits = {2'b11, b, 1'b0};
		for (int k = 0; k < 11; k++) begin
			@(posedge sys_clk);
			#1;
			raw_rx = bits[k] ? (raw_rx | mask) : (raw_rx & ~mask);
			repeat (CLKS - 1) @(posedge sys_clk);
		end
		gap = rand_bits(3);
		repeat (gap) @(posedge sys_clk);
	endtask

	task automatic run_vector(input int n);
		chan_id_t          ch;
		logic [NUM_CH-1:0] mask;
		rx_frame_s         exp_a;
		rx_frame_s         exp_b;
		tx_string_s        junk;
		int                n_frames;
		int                n_done;
		int                busy_rd;
		int                done_base [NUM_CH];
		ch       = vec_chan[n];
		mask     = NUM_CH'(1) << ch;
		exp_a    = make_frame(ch, n, 1'b1);
		exp_b    = exp_a;
		n_frames = 1;
		n_done   = 0;
		busy_rd  = busy_at_done.size();
		done_base = done_cnt;
		case (vec_mode[n])
			"L": begin
				n_done = 1;
				send_when_free(ch, payload_of(make_frame(ch, n, 1'b0)));
			end
			"P": begin
				n_frames = 2;
				n_done   = 2;
				exp_a    = make_frame(ch, n, 1'b0);
				send_when_free(ch, payload_of(exp_a));
				send_when_free(ch, payload_of(exp_b));
				check_flag(tx_busy, 1'b1, "tx_busy with a string held");
				// dispatcher is full, so this request must vanish
				junk.data   = ~exp_b.data;
				junk.length = exp_b.length;
				host_pulse(ch, junk);
			end
			"R", "C": begin
				if (vec_mode[n] == "C") begin
					mask       = mask | (mask << 1);
					n_frames   = 2;
					exp_b.chan = ch + 1'b1;
				end
				loop_sel = ~mask;
				for (int k = 0; k < vec_cnt[n]; k++) begin
					send_raw_byte(mask, vec_bytes[n][k]);
				end
			end
			default: stop_on_error("the stimulus file holds an unknown vector mode");
		endcase
		while (rx_q.size() - rx_rd < n_frames || done_cnt[ch] - done_base[ch] < n_done) begin
			@(posedge sys_clk);
		end
		repeat (4) @(posedge sys_clk);
		loop_sel = '1;
		check_frame(rx_q[rx_rd], exp_a);
		rx_rd++;
		if (n_frames == 2) begin
			check_frame(rx_q[rx_rd], exp_b);
			rx_rd++;
		end
		check_count(rx_q.size() - rx_rd, 0, "extra rx frames");
		for (int i = 0; i < NUM_CH; i++) begin
			check_count(done_cnt[i] - done_base[i], (i == int'(ch)) ? n_done : 0,
				$sformatf("tx_done pulses on channel %0d", i));
		end
		if (vec_mode[n] == "P") begin
			check_flag(busy_at_done[busy_rd], 1'b1, "tx_busy at the first tx_done");
		end
	endtask

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		stop_on_error($sformatf("watchdog expired after %0d ns, the DUT stopped responding",
			limit_ns));
	end

	initial begin
		sys_clk    = 1'b0;
		sys_rst_n  = 1'b0;
		tx_req     = 1'b0;
		tx_chan    = '0;
		tx_str     = '0;
		loop_sel   = '1;
		raw_rx     = '1;
		rx_rd      = 0;
		lfsr_state = 32'ha5a7;
		limit_ns   = 0;
		for (int i = 0; i < NUM_CH; i++) begin
			done_cnt[i] = 0;
		end
		load_vectors();
		limit_ns = longint'(vector_bytes() + 24) * 12 * CLKS * 100;
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_flag(tx_busy, 1'b0, "tx_busy after reset");
		check_flag(|tx_done, 1'b0, "tx_done after reset");
		check_flag(rx_valid, 1'b0, "rx_valid after reset");
		check_flag(&uart_tx, 1'b1, "uart_tx idle level after reset");
		for (int n = 0; n < num_vec; n++) begin
			run_vector(n);
		end
		repeat (4 * CLKS) @(posedge sys_clk);
		if (rx_q.size() == rx_rd) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stop_on_error("rx frames arrived after the last vector");
		end
	end

endmodule

/* vlog.f */
+incdir+include
source/uart_data_pkg.sv
source/uart_ctrl_pkg.sv
source/uart_tx_dispatch.sv
source/uart_byte_tx.sv
source/uart_byte_rx.sv
source/uart_frame_channel.sv
source/uart_frame_collector.sv
source/uart_string_hub.sv
verification/uart_string_hub_tb.sv

/* Makefile */
# Verilator build and run of the uart string hub testbench

TOP       ?= uart_string_hub_tb
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP LOG VERILATOR FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/uart_hub_stimulus.txt */
# mode chan count bytes exp_len exp_bytes; counts decimal, bytes hex, may wrap lines
# L loopback send, R raw rx bytes, C raw rx on chan and chan+1, P queued pair (bytes, exp)
L 0 5 48 65 6c 6c 6f 5 48 65 6c 6c 6f
L 1 3 41 42 43 3 41 42 43
L 2 1 5a 1 5a
L 3 16 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
  16 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
L 1 0 0
L 2 4 26 41 26 42 4 26 41 26 42
R 2 4 26 26 26 26 0
R 0 7 26 26 41 26 78 26 26 3 41 26 78
R 1 6 26 26 26 78 26 26 2 26 78
R 3 10 55 aa 26 41 26 26 4f 4b 26 26 2 4f 4b
P 3 2 50 31 2 50 32
R 3 22 26 26 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 26 26
  16 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70
C 1 5 26 26 51 26 26 1 51
C 0 4 26 26 26 26 0
